/* hdl/nrvPkg.sv */
// RV32I base subset only; FENCE, SYSTEM and CSRs are outside the set and decode as illegal
package nrvPkg;

   typedef logic [31:0] xlenT;     // Data word, PC or instruction word
   typedef logic [4:0]  regIdT;    // Register index x0..x31
   typedef logic [2:0]  aluFuncT;  // Instruction bits 14:12

   // Major opcodes, instruction bits 6:2 (bits 1:0 are always 11)
   localparam logic [4:0] OpLui    = 5'b01101;
   localparam logic [4:0] OpAuipc  = 5'b00101;
   localparam logic [4:0] OpJal    = 5'b11011;
   localparam logic [4:0] OpJalr   = 5'b11001;
   localparam logic [4:0] OpBranch = 5'b11000;
   localparam logic [4:0] OpAluImm = 5'b00100;
   localparam logic [4:0] OpAluReg = 5'b01100;
   localparam logic [4:0] OpLoad   = 5'b00000;
   localparam logic [4:0] OpStore  = 5'b01000;

   // ALU function codes, shared by decoder and ALU
   localparam aluFuncT FuncAdd  = 3'b000;  // ADD/SUB
   localparam aluFuncT FuncSll  = 3'b001;
   localparam aluFuncT FuncSlt  = 3'b010;
   localparam aluFuncT FuncSltu = 3'b011;
   localparam aluFuncT FuncXor  = 3'b100;
   localparam aluFuncT FuncSr   = 3'b101;  // SRL/SRA
   localparam aluFuncT FuncOr   = 3'b110;
   localparam aluFuncT FuncAnd  = 3'b111;

   // Write-back source select
   localparam logic [1:0] WbAlu    = 2'd0;
   localparam logic [1:0] WbPc4    = 2'd1;
   localparam logic [1:0] WbAplusB = 2'd2;

   localparam int IssueDepth  = 2;  // Main plus skid entry
   localparam int RetireDepth = 2;
   localparam int IssueCntW   = $clog2(IssueDepth + 1);
   localparam int RetirePtrW  = $clog2(RetireDepth);
   localparam int RetireCntW  = $clog2(RetireDepth + 1);

   typedef logic [IssueCntW-1:0]  issueCntT;
   typedef logic [RetirePtrW-1:0] retirePtrT;
   typedef logic [RetireCntW-1:0] retireCntT;

   typedef struct packed {
      xlenT pc;
      xlenT instr;
   } issueT;

   typedef struct packed {
      regIdT      rd;
      regIdT      rs1;        // Zero for LUI so that A+B gives the immediate
      regIdT      rs2;
      aluFuncT    func;
      logic       funcQual;   // SUB / SRA qualifier
      logic       wbEn;
      logic [1:0] wbSrc;
      logic       aluSelPc;   // A operand: 1 pc, 0 rs1
      logic       aluSelImm;  // B operand: 1 imm, 0 rs2
      logic       isAlu;
      logic       isLoad;
      logic       isStore;
      logic       isBranch;
      logic       isJump;
      xlenT       imm;
      logic       illegal;
   } decodeT;

   typedef struct packed {
      xlenT    pc;
      xlenT    nextPc;
      regIdT   rd;
      logic    wbEn;
      xlenT    wbData;
      logic    memRead;
      logic    memWrite;
      xlenT    memAddr;
      xlenT    storeData;
      aluFuncT memFunc;   // Access width and sign, same as func
      logic    illegal;
   } retireT;

endpackage

/* hdl/nrvDecoder.sv */
// Purely combinational; funct7 is not checked beyond bit 30, unknown opcodes or low bits != 11 flag illegal
`timescale 1ns/1ps

module nrvDecoder (
   input  nrvPkg::xlenT   instr,  // Instruction word to decode
   output nrvPkg::decodeT dec     // Control fields, immediate and illegal flag
);

   nrvPkg::xlenT iImm;
   nrvPkg::xlenT sImm;
   nrvPkg::xlenT bImm;
   nrvPkg::xlenT jImm;
   nrvPkg::xlenT uImm;
   logic         funcIsShift;

   // Sign always comes from bit 31
   assign iImm = {{21{instr[31]}}, instr[30:20]};
   assign sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   assign uImm = {instr[31:12], 12'b0};

   assign funcIsShift = (instr[14:12] == nrvPkg::FuncSll) || (instr[14:12] == nrvPkg::FuncSr);

   always_comb begin
      dec          = '0;
      dec.rd       = instr[11:7];     // Fixed-position fields
      dec.rs1      = instr[19:15];
      dec.rs2      = instr[24:20];
      dec.func     = instr[14:12];
      dec.wbSrc    = nrvPkg::WbAlu;
      dec.imm      = iImm;

      case (instr[6:2])
         nrvPkg::OpLui: begin
            dec.wbEn      = 1'b1;
            dec.wbSrc     = nrvPkg::WbAplusB;  // x0 + U imm
            dec.rs1       = '0;
            dec.aluSelImm = 1'b1;
            dec.imm       = uImm;
         end
         nrvPkg::OpAuipc: begin
            dec.wbEn      = 1'b1;
            dec.wbSrc     = nrvPkg::WbAplusB;  // pc + U imm
            dec.aluSelPc  = 1'b1;
            dec.aluSelImm = 1'b1;
            dec.imm       = uImm;
         end
         nrvPkg::OpJal: begin
            dec.wbEn      = 1'b1;
            dec.wbSrc     = nrvPkg::WbPc4;     // Link value
            dec.aluSelPc  = 1'b1;              // Target pc + J imm
            dec.aluSelImm = 1'b1;
            dec.isJump    = 1'b1;
            dec.imm       = jImm;
         end
         nrvPkg::OpJalr: begin
            dec.wbEn      = 1'b1;
            dec.wbSrc     = nrvPkg::WbPc4;
            dec.aluSelImm = 1'b1;              // Target rs1 + I imm
            dec.isJump    = 1'b1;
         end
         nrvPkg::OpBranch: begin
            dec.aluSelPc  = 1'b1;              // Target pc + B imm, condition on rs1/rs2
            dec.aluSelImm = 1'b1;
            dec.isBranch  = 1'b1;
            dec.imm       = bImm;
         end
         nrvPkg::OpAluImm: begin
            dec.wbEn      = 1'b1;
            dec.aluSelImm = 1'b1;
            dec.funcQual  = funcIsShift ? instr[30] : 1'b0;  // SRAI only, ADDI has no SUBI
            dec.isAlu     = 1'b1;
         end
         nrvPkg::OpAluReg: begin
            dec.wbEn      = 1'b1;
            dec.funcQual  = instr[30];         // SUB / SRA
            dec.isAlu     = 1'b1;
         end
         nrvPkg::OpLoad: begin
            dec.aluSelImm = 1'b1;              // Address rs1 + I imm, no data return
            dec.isLoad    = 1'b1;
         end
         nrvPkg::OpStore: begin
            dec.aluSelImm = 1'b1;
            dec.isStore   = 1'b1;
            dec.imm       = sImm;
         end
         default: begin
            dec.illegal   = 1'b1;              // FENCE, SYSTEM and unknown opcodes
         end
      endcase

      if (instr[1:0] != 2'b11) begin
         dec.illegal = 1'b1;                   // Compressed or garbage encoding
      end

      // Illegal instructions must not write or touch memory
      if (dec.illegal) begin
         dec.wbEn     = 1'b0;
         dec.isAlu    = 1'b0;
         dec.isLoad   = 1'b0;
         dec.isStore  = 1'b0;
         dec.isBranch = 1'b0;
         dec.isJump   = 1'b0;
      end
   end

endmodule

/* hdl/nrvIssueBuffer.sv */
// Two-entry skid buffer; inReady is a pure flop output, head data is valid the cycle after accept
`timescale 1ns/1ps

module nrvIssueBuffer (
   input  logic          clk,
   input  logic          rstN,
   input  logic          inValid,
   output logic          inReady,
   input  nrvPkg::issueT inData,
   output logic          headValid,
   input  logic          headReady,
   output nrvPkg::issueT head
);

   nrvPkg::issueCntT occ;    // Entries held, 0..IssueDepth
   nrvPkg::issueT    mainQ;  // Entry seen by execute
   nrvPkg::issueT    skidQ;  // Word caught while head stalled
   logic             push;
   logic             pop;
   logic             isEmpty;
   logic             isFull;

   assign isEmpty   = (occ == '0);
   assign isFull    = (occ == nrvPkg::issueCntT'(nrvPkg::IssueDepth));
   assign inReady   = !isFull;             // High while a slot is free
   assign headValid = !isEmpty;
   assign head      = mainQ;
   assign push      = inValid && inReady;
   assign pop       = headValid && headReady;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         occ <= '0;
      end else begin
         occ <= occ + nrvPkg::issueCntT'(push) - nrvPkg::issueCntT'(pop);
      end
   end

   always_ff @(posedge clk) begin
      if (isFull && pop) begin
         mainQ <= skidQ;                   // Skid word moves up, nothing new can arrive
      end else if (push && (isEmpty || pop)) begin
         mainQ <= inData;                  // Straight into head slot
      end
      if (push && !isEmpty && !pop) begin
         skidQ <= inData;                  // Head stalled, park the new word
      end
   end

endmodule

/* hdl/nrvRegFile.sv */
// 32x32 register file; reads are combinational, x0 always reads zero and ignores writes
`timescale 1ns/1ps

module nrvRegFile (
   input  logic          clk,
   input  logic          rstN,
   input  nrvPkg::regIdT rs1,
   input  nrvPkg::regIdT rs2,
   output nrvPkg::xlenT  rdata1,
   output nrvPkg::xlenT  rdata2,
   input  logic          wrEn,
   input  nrvPkg::regIdT wrId,
   input  nrvPkg::xlenT  wrData
);

   nrvPkg::xlenT regs [32];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn && (wrId != '0)) begin
         regs[wrId] <= wrData;                   // x0 stays untouched
      end
   end

   assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];  // Hard zero for x0
   assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hdl/nrvAlu.sv */
// Single-cycle ALU; shifts use opB[4:0] only, non-ALU ops get the plain sum for addresses and targets
`timescale 1ns/1ps

module nrvAlu (
   input  nrvPkg::xlenT    opA,
   input  nrvPkg::xlenT    opB,
   input  nrvPkg::aluFuncT func,
   input  logic            funcQual,     // SUB / SRA when set
   input  logic            isAlu,
   input  nrvPkg::xlenT    cmpA,         // Branch compare, always rs1
   input  nrvPkg::xlenT    cmpB,         // Branch compare, always rs2
   output nrvPkg::xlenT    result,
   output logic            branchTaken
);

   nrvPkg::xlenT sum;
   nrvPkg::xlenT diff;
   logic [4:0]   shamt;

   assign sum   = opA + opB;
   assign diff  = opA - opB;
   assign shamt = opB[4:0];

   always_comb begin
      result = sum;                          // Address / target / LUI / AUIPC
      if (isAlu) begin
         case (func)
            nrvPkg::FuncAdd:  result = funcQual ? diff : sum;
            nrvPkg::FuncSll:  result = opA << shamt;
            nrvPkg::FuncSlt:  result = {31'b0, $signed(opA) < $signed(opB)};
            nrvPkg::FuncSltu: result = {31'b0, opA < opB};
            nrvPkg::FuncXor:  result = opA ^ opB;
            nrvPkg::FuncSr:   result = funcQual ? nrvPkg::xlenT'($signed(opA) >>> shamt)
                                                : opA >> shamt;
            nrvPkg::FuncOr:   result = opA | opB;
            nrvPkg::FuncAnd:  result = opA & opB;
            default:          result = sum;
         endcase
      end
   end

   // Branch condition by func; 010/011 are not valid branches
   always_comb begin
      case (func)
         3'b000:  branchTaken = (cmpA == cmpB);                   // BEQ
         3'b001:  branchTaken = (cmpA != cmpB);                   // BNE
         3'b100:  branchTaken = ($signed(cmpA) < $signed(cmpB));  // BLT
         3'b101:  branchTaken = ($signed(cmpA) >= $signed(cmpB)); // BGE
         3'b110:  branchTaken = (cmpA < cmpB);                    // BLTU
         3'b111:  branchTaken = (cmpA >= cmpB);                   // BGEU
         default: branchTaken = 1'b0;
      endcase
   end

endmodule

/* hdl/nrvExecute.sv */
// Zero-cycle execute stage; register write commits on the retire handshake so no hazard logic exists
`timescale 1ns/1ps

module nrvExecute (
   input  logic           clk,
   input  logic           rstN,
   input  logic           headValid,
   output logic           headReady,
   input  nrvPkg::issueT  head,
   output logic           retValid,
   input  logic           retReady,
   output nrvPkg::retireT retData
);

   nrvPkg::decodeT dec;
   nrvPkg::xlenT   rdata1;
   nrvPkg::xlenT   rdata2;
   nrvPkg::xlenT   opA;
   nrvPkg::xlenT   opB;
   nrvPkg::xlenT   aluResult;
   logic           branchTaken;
   nrvPkg::xlenT   pcPlus4;
   nrvPkg::xlenT   wbData;
   nrvPkg::xlenT   nextPc;
   logic           isJalr;
   logic           commit;

   nrvDecoder nrvDecoder_i (
      .instr (head.instr),
      .dec   (dec)
   );

   nrvRegFile nrvRegFile_i (
      .clk    (clk),
      .rstN   (rstN),
      .rs1    (dec.rs1),
      .rs2    (dec.rs2),
      .rdata1 (rdata1),
      .rdata2 (rdata2),
      .wrEn   (commit && dec.wbEn),    // Write lands with the retire transfer
      .wrId   (dec.rd),
      .wrData (wbData)
   );

   assign opA = dec.aluSelPc  ? head.pc : rdata1;
   assign opB = dec.aluSelImm ? dec.imm : rdata2;

   nrvAlu nrvAlu_i (
      .opA         (opA),
      .opB         (opB),
      .func        (dec.func),
      .funcQual    (dec.funcQual),
      .isAlu       (dec.isAlu),
      .cmpA        (rdata1),
      .cmpB        (rdata2),
      .result      (aluResult),
      .branchTaken (branchTaken)
   );

   assign retValid  = headValid;   // Pass-through handshake
   assign headReady = retReady;
   assign commit    = retValid && retReady;
   assign pcPlus4   = head.pc + 32'd4;
   assign isJalr    = dec.isJump && !dec.aluSelPc;

   always_comb begin
      case (dec.wbSrc)
         nrvPkg::WbPc4:    wbData = pcPlus4;     // JAL / JALR link
         nrvPkg::WbAplusB: wbData = opA + opB;   // LUI / AUIPC
         default:          wbData = aluResult;
      endcase
   end

   always_comb begin
      if (isJalr) begin
         nextPc = {aluResult[31:1], 1'b0};       // JALR clears bit 0
      end else if (dec.isJump || (dec.isBranch && branchTaken)) begin
         nextPc = aluResult;
      end else begin
         nextPc = pcPlus4;
      end
   end

   always_comb begin
      retData.pc        = head.pc;
      retData.nextPc    = nextPc;
      retData.rd        = dec.rd;
      retData.wbEn      = dec.wbEn;              // Already cleared for illegal ops
      retData.wbData    = wbData;
      retData.memRead   = dec.isLoad;
      retData.memWrite  = dec.isStore;
      retData.memAddr   = aluResult;             // rs1 + imm
      retData.storeData = rdata2;
      retData.memFunc   = dec.func;
      retData.illegal   = dec.illegal;
   end

endmodule

/* hdl/nrvRetireQueue.sv */
// RetireDepth-entry FIFO; no bypass, so a written record shows on outValid one cycle later
`timescale 1ns/1ps

module nrvRetireQueue (
   input  logic           clk,
   input  logic           rstN,
   input  logic           retValid,
   output logic           retReady,
   input  nrvPkg::retireT retData,
   output logic           outValid,
   input  logic           outReady,
   output nrvPkg::retireT outData
);

   nrvPkg::retireT    mem [nrvPkg::RetireDepth];
   nrvPkg::retirePtrT wrPtr;
   nrvPkg::retirePtrT rdPtr;
   nrvPkg::retireCntT count;
   logic              wrEn;
   logic              rdEn;

   function automatic nrvPkg::retirePtrT nextPtr(input nrvPkg::retirePtrT ptr);
      nextPtr = (ptr == nrvPkg::retirePtrT'(nrvPkg::RetireDepth - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign retReady = (count != nrvPkg::retireCntT'(nrvPkg::RetireDepth));
   assign outValid = (count != '0);
   assign outData  = mem[rdPtr];
   assign wrEn     = retValid && retReady;
   assign rdEn     = outValid && outReady;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (wrEn) begin
            wrPtr <= nextPtr(wrPtr);
         end
         if (rdEn) begin
            rdPtr <= nextPtr(rdPtr);
         end
         count <= count + nrvPkg::retireCntT'(wrEn) - nrvPkg::retireCntT'(rdEn);
      end
   end

   always_ff @(posedge clk) begin
      if (wrEn) begin
         mem[wrPtr] <= retData;   // New record at the tail
      end
   end

endmodule

/* hdl/nrvExecUnit.sv */
// Top of the RV32I execute unit; two edges from input to output handshake when outReady stays high
`timescale 1ns/1ps

module nrvExecUnit (
   input  logic           clk,
   input  logic           rstN,
   input  logic           inValid,
   output logic           inReady,
   input  nrvPkg::issueT  inData,
   output logic           outValid,
   input  logic           outReady,
   output nrvPkg::retireT outData
);

   logic           headValid;
   logic           headReady;
   nrvPkg::issueT  head;
   logic           retValid;
   logic           retReady;
   nrvPkg::retireT retData;

   nrvIssueBuffer nrvIssueBuffer_i (
      .clk       (clk),
      .rstN      (rstN),
      .inValid   (inValid),
      .inReady   (inReady),
      .inData    (inData),
      .headValid (headValid),
      .headReady (headReady),
      .head      (head)
   );

   nrvExecute nrvExecute_i (
      .clk       (clk),
      .rstN      (rstN),
      .headValid (headValid),
      .headReady (headReady),
      .head      (head),
      .retValid  (retValid),
      .retReady  (retReady),
      .retData   (retData)
   );

   nrvRetireQueue nrvRetireQueue_i (
      .clk      (clk),
      .rstN     (rstN),
      .retValid (retValid),
      .retReady (retReady),
      .retData  (retData),
      .outValid (outValid),
      .outReady (outReady),
      .outData  (outData)
   );

endmodule

/* test/nrvExecUnit_checker.sv */
// Watches only the output port; handshake checks are off while rstN is low, except the reset check
`timescale 1ns/1ps

module nrvExecUnit_checker (
   input logic           clk,
   input logic           rstN,
   input logic           outValid,
   input logic           outReady,
   input nrvPkg::retireT outData
);

   int failCount = 0;  // Read by the testbench at the end of the run

   // Retire queue is emptied by reset
   resetQuiet: assert property (@(posedge clk) !rstN |-> !outValid)
      else begin
         failCount++;
         $error("outValid high while rstN is low");
      end

   // Consumer stall must not disturb the offered record
   holdStable: assert property (@(posedge clk) disable iff (!rstN)
      (outValid && !outReady) |=> (outValid && $stable(outData)))
      else begin
         failCount++;
         $error("Output record dropped or changed while stalled");
      end

   illegalQuiet: assert property (@(posedge clk) disable iff (!rstN)
      (outValid && outData.illegal) |-> !(outData.wbEn || outData.memRead || outData.memWrite))
      else begin
         failCount++;
         $error("Illegal instruction retired with a write or memory request");
      end

endmodule

/* test/nrvExecUnit_tb.sv */
// Random RV32I stream from a fixed seed; load data never returns, illegal records check only flags
`timescale 1ns/1ps

module nrvExecUnit_tb;

   localparam int          ClkPeriod      = 8;
   localparam int          NumInstr       = 1500;
   localparam int          WatchdogCycles = NumInstr * 20;
   localparam logic [31:0] Seed           = 32'hbdce_2f31;

   logic           clk;
   logic           rstN;
   logic           inValid;
   logic           inReady;
   nrvPkg::issueT  inData;
   logic           outValid;
   logic           outReady;
   nrvPkg::retireT outData;

   nrvPkg::retireT expQ [$];         // Expected records in program order
   logic [31:0]    modelRegs [32];   // Architectural state seen by the model
   int             recvCount;

   nrvExecUnit nrvExecUnit_i (
      .clk      (clk),
      .rstN     (rstN),
      .inValid  (inValid),
      .inReady  (inReady),
      .inData   (inData),
      .outValid (outValid),
      .outReady (outReady),
      .outData  (outData)
   );

   bind nrvExecUnit nrvExecUnit_checker nrvExecUnit_checker_i (
      .clk      (clk),
      .rstN     (rstN),
      .outValid (outValid),
      .outReady (outReady),
      .outData  (outData)
   );

   initial begin
      clk = 1'b0;
      forever #(ClkPeriod / 2) clk = ~clk;
   end

   initial begin
      #(WatchdogCycles * ClkPeriod);
      $display("Run hung: %0d of %0d records retired after %0d cycles",
               recvCount, NumInstr, WatchdogCycles);
      $display("TEST FAILED");
      $fatal(1, "Watchdog expired");
   end

   task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%h expected 0x%h (record %0d)", name, got, exp, recvCount);
         $display("TEST FAILED");
         $fatal(1, "Value mismatch");
      end
   endtask

   function automatic logic [31:0] readReg(input logic [4:0] id);
      return (id == 5'd0) ? 32'd0 : modelRegs[id];   // x0 reads zero
   endfunction

   function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic qual,
                                            input logic [31:0] a, input logic [31:0] b);
      logic [31:0] res;
      case (f3)
         3'b000:  res = qual ? a - b : a + b;
         3'b001:  res = a << b[4:0];
         3'b010:  res = {31'b0, $signed(a) < $signed(b)};
         3'b011:  res = {31'b0, a < b};
         3'b100:  res = a ^ b;
         3'b101: begin
            if (qual) begin
               res = $signed(a) >>> b[4:0];    // Sign fill
            end else begin
               res = a >> b[4:0];
            end
         end
         3'b110:  res = a | b;
         default: res = a & b;
      endcase
      return res;
   endfunction

   function automatic logic branchModel(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
      case (f3)
         3'b000:  return a == b;
         3'b001:  return a != b;
         3'b100:  return $signed(a) < $signed(b);
         3'b101:  return $signed(a) >= $signed(b);
         3'b110:  return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic logic opcodeKnown(input logic [31:0] w);
      logic known;
      case (w[6:2])
         nrvPkg::OpLui, nrvPkg::OpAuipc, nrvPkg::OpJal, nrvPkg::OpJalr, nrvPkg::OpBranch,
         nrvPkg::OpAluImm, nrvPkg::OpAluReg, nrvPkg::OpLoad, nrvPkg::OpStore: known = 1'b1;
         default: known = 1'b0;
      endcase
      return known && (w[1:0] == 2'b11);
   endfunction

   // Weighted instruction classes, model state advances in program order
   task automatic makeInstr(input logic [31:0] pc, output logic [31:0] instr,
                            output nrvPkg::retireT exp);
      int unsigned pick;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [2:0]  f3;
      logic        qual;
      logic [31:0] raw;
      logic [31:0] imm;
      logic [31:0] off;
      logic [31:0] a;
      logic [31:0] b;
      pick = $urandom_range(99);
      rd   = ($urandom_range(3) == 0) ? 5'($urandom) : 5'($urandom_range(7));  // Dense reuse
      rs1  = 5'($urandom_range(7));
      rs2  = 5'($urandom_range(7));
      f3   = 3'($urandom);
      qual = 1'b0;
      raw  = $urandom;
      imm  = {{20{raw[11]}}, raw[11:0]};
      a    = readReg(rs1);
      b    = readReg(rs2);
      exp         = '0;
      exp.pc      = pc;
      exp.nextPc  = pc + 32'd4;
      exp.rd      = rd;
      exp.memFunc = f3;
      if (pick < 22) begin
         if (f3 == 3'b001 || f3 == 3'b101) begin
            qual = (f3 == 3'b101) && ($urandom_range(1) == 1);
            imm  = {20'b0, 1'b0, qual, 5'b0, raw[4:0]};          // SRAI sets bit 30
         end
         instr      = {imm[11:0], rs1, f3, rd, nrvPkg::OpAluImm, 2'b11};
         exp.wbEn   = 1'b1;
         exp.wbData = aluModel(f3, qual, a, imm);
      end else if (pick < 42) begin
         qual       = (f3 == 3'b000 || f3 == 3'b101) && ($urandom_range(1) == 1);
         instr      = {1'b0, qual, 5'b0, rs2, rs1, f3, rd, nrvPkg::OpAluReg, 2'b11};
         exp.wbEn   = 1'b1;
         exp.wbData = aluModel(f3, qual, a, b);
      end else if (pick < 50) begin
         instr      = {raw[31:12], rd, nrvPkg::OpLui, 2'b11};
         exp.wbEn   = 1'b1;
         exp.wbData = {raw[31:12], 12'b0};
      end else if (pick < 55) begin
         instr      = {raw[31:12], rd, nrvPkg::OpAuipc, 2'b11};
         exp.wbEn   = 1'b1;
         exp.wbData = pc + {raw[31:12], 12'b0};
      end else if (pick < 67) begin
         if (f3[2:1] == 2'b01) begin
            f3[2] = 1'b1;                                          // 010/011 are no branches
         end
         off   = {{19{raw[12]}}, raw[12:1], 1'b0};
         instr = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], nrvPkg::OpBranch, 2'b11};
         if (branchModel(f3, a, b)) begin
            exp.nextPc = pc + off;
         end
      end else if (pick < 72) begin
         off        = {{11{raw[20]}}, raw[20:1], 1'b0};
         instr      = {off[20], off[10:1], off[11], off[19:12], rd, nrvPkg::OpJal, 2'b11};
         exp.wbEn   = 1'b1;
         exp.wbData = pc + 32'd4;
         exp.nextPc = pc + off;
      end else if (pick < 77) begin
         instr      = {imm[11:0], rs1, 3'b000, rd, nrvPkg::OpJalr, 2'b11};
         exp.wbEn   = 1'b1;
         exp.wbData = pc + 32'd4;
         exp.nextPc = (a + imm) & ~32'd1;                          // Old rs1, even if rd == rs1
      end else if (pick < 86) begin
         instr       = {imm[11:0], rs1, f3, rd, nrvPkg::OpLoad, 2'b11};
         exp.memRead = 1'b1;
         exp.memAddr = a + imm;
      end else if (pick < 95) begin
         instr         = {imm[11:5], rs2, rs1, f3, imm[4:0], nrvPkg::OpStore, 2'b11};
         exp.memWrite  = 1'b1;
         exp.memAddr   = a + imm;
         exp.storeData = b;
      end else begin
         if ($urandom_range(1) == 1) begin
            raw[6:0] = ($urandom_range(1) == 1) ? 7'b0001111 : 7'b1110011;  // FENCE / SYSTEM
         end
         if (opcodeKnown(raw)) begin
            raw[0] = 1'b0;                                         // Break the low bits
         end
         instr       = raw;
         exp.illegal = 1'b1;
      end
      if (exp.wbEn && rd != 5'd0) begin
         modelRegs[rd] = exp.wbData;
      end
   endtask

   task automatic driveInstrs();
      logic [31:0]    pc;
      logic [31:0]    word;
      nrvPkg::retireT exp;
      logic           sent;
      pc = 32'h0000_1000;
      for (int n = 0; n < NumInstr; n++) begin
         while ($urandom_range(99) < 20) begin
            @(posedge clk);                  // Idle gap on the input
            #1;
         end
         makeInstr(pc, word, exp);
         expQ.push_back(exp);
         inData.pc    = pc;
         inData.instr = word;
         inValid      = 1'b1;
         do begin
            sent = inReady;                  // Registered, stable until the next edge
            @(posedge clk);
            #1;
         end while (!sent);
         inValid = 1'b0;
         pc      = pc + 32'd4;
      end
   endtask

   task automatic checkRecord(input nrvPkg::retireT got);
      nrvPkg::retireT exp;
      if (expQ.size() == 0) begin
         $display("Output record appeared with no instruction outstanding");
         $display("TEST FAILED");
         $fatal(1, "Unexpected output");
      end
      exp = expQ.pop_front();
      checkEq("illegal", got.illegal, exp.illegal);
      checkEq("wbEn", got.wbEn, exp.wbEn);
      checkEq("memRead", got.memRead, exp.memRead);
      checkEq("memWrite", got.memWrite, exp.memWrite);
      if (!exp.illegal) begin
         checkEq("pc", got.pc, exp.pc);
         checkEq("nextPc", got.nextPc, exp.nextPc);
         if (exp.wbEn) begin
            checkEq("rd", got.rd, exp.rd);
            checkEq("wbData", got.wbData, exp.wbData);
         end
         if (exp.memRead || exp.memWrite) begin
            checkEq("memAddr", got.memAddr, exp.memAddr);
            checkEq("memFunc", got.memFunc, exp.memFunc);
         end
         if (exp.memWrite) begin
            checkEq("storeData", got.storeData, exp.storeData);
         end
      end
   endtask

   task automatic collectRecords();
      while (recvCount < NumInstr) begin
         @(posedge clk);
         #1;
         outReady = ($urandom_range(99) < 50);
         if (outValid && outReady) begin
            checkRecord(outData);            // Transfer completes on the coming edge
            recvCount++;
         end
      end
   endtask

   initial begin
      void'($urandom(Seed));
      rstN      = 1'b0;
      inValid   = 1'b0;
      inData    = '0;
      outReady  = 1'b0;
      recvCount = 0;
      for (int i = 0; i < 32; i++) begin
         modelRegs[i] = 32'd0;
      end
      repeat (3) @(posedge clk);
      #1;
      rstN = 1'b1;
      checkEq("inReady", inReady, 32'd1);
      checkEq("outValid", outValid, 32'd0);
      fork
         driveInstrs();
         collectRecords();
      join
      outReady = 1'b1;
      repeat (4) begin
         @(posedge clk);
         #1;
      end
      checkEq("outValid", outValid, 32'd0);  // Nothing beyond the last record
      if (expQ.size() != 0 || nrvExecUnit_i.nrvExecUnit_checker_i.failCount != 0) begin
         $display("%0d expected records left, %0d assertion failures", expQ.size(),
                  nrvExecUnit_i.nrvExecUnit_checker_i.failCount);
         $display("TEST FAILED");
         $fatal(1, "Run ended with errors");
      end else begin
         $display("TEST PASSED");
         $finish;
      end
   end

endmodule

/* nrvExecUnit.f */
hdl/nrvPkg.sv
hdl/nrvDecoder.sv
hdl/nrvIssueBuffer.sv
hdl/nrvRegFile.sv
hdl/nrvAlu.sv
hdl/nrvExecute.sv
hdl/nrvRetireQueue.sv
hdl/nrvExecUnit.sv
test/nrvExecUnit_checker.sv
test/nrvExecUnit_tb.sv

/* Bender.yml */
package:
  name: nrvExecUnit

sources:
  - hdl/nrvPkg.sv
  - hdl/nrvDecoder.sv
  - hdl/nrvIssueBuffer.sv
  - hdl/nrvRegFile.sv
  - hdl/nrvAlu.sv
  - hdl/nrvExecute.sv
  - hdl/nrvRetireQueue.sv
  - hdl/nrvExecUnit.sv
  - target: test
    files:
      - test/nrvExecUnit_checker.sv
      - test/nrvExecUnit_tb.sv
